// File: include/cl_ctl_status_cfg.svh
// -------------------------------------------------------------------------
// Sized for four scrubbers and three local DDR stat channels
// -------------------------------------------------------------------------
`ifndef CL_CTL_STATUS_CFG_SVH
`define CL_CTL_STATUS_CFG_SVH

// Scrubber and stat channel counts
`define CFG_NUM_SCRB         4
`define CFG_NUM_DDR_STAT     3
`define CFG_DDR_STAT_STAGES  8

// Stat channel field widths
`define CFG_STAT_ADDR_W      8
`define CFG_STAT_DATA_W      32
`define CFG_STAT_INT_W       8

// Scrubber progress
`define CFG_SCRB_STATE_W     3
`define CFG_SCRB_ADDR_W      64

// ID words shown when debug readout is off
`define CFG_CL_SH_ID0        32'hF001_1D0F
`define CFG_CL_SH_ID1        32'h1D51_FEDD

`define CFG_STATUS_SIGNATURE 20'hA1111
`define CFG_STATUS_MARKER    4'hF

`endif

// File: source/cl_ctl_status_pkg.sv
// -------------------------------------------------------------------------
// Both status layouts must stay exactly 32 bits wide
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

package cl_ctl_status_pkg;

   // Normal layout, signature in the upper bits
   typedef struct packed {
      logic [19:0]                     signature;
      logic [3:0]                      marker;
      logic [`CFG_NUM_SCRB-1:0]        scrb_done;
      logic [`CFG_NUM_DDR_STAT:0]      ddr_ready;
   } status_normal_t;

   // Debug layout
   // One nibble per scrubber, pad bit above the state, index 3 on top
   typedef struct packed {
      logic [`CFG_NUM_SCRB-1:0][`CFG_SCRB_STATE_W:0] scrb_fld;
      logic [3:0]                                    rsvd;
      logic [3:0]                                    marker;
      logic [`CFG_NUM_SCRB-1:0]                      scrb_done;
      logic [`CFG_NUM_DDR_STAT:0]                    ddr_ready;
   } status_debug_t;

   // Status word, decoded by the debug enable
   typedef union packed {
      status_normal_t nrm;
      status_debug_t  dbg;
   } status_word_u;

endpackage

`default_nettype wire

// File: source/ctl_if.sv
// -------------------------------------------------------------------------
// Plain levels only, no handshake
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

interface ctl_if;

   // Decoded control word
   logic [`CFG_NUM_SCRB-1:0]   scrb_en;
   logic                       dbg_en;
   logic [2:0]                 dbg_mem_sel;

   // {local 2, external, local 1..0}
   logic [`CFG_NUM_DDR_STAT:0] ddr_ready;

   modport capture (output scrb_en, dbg_en, dbg_mem_sel, ddr_ready);
   modport report  (input  scrb_en, dbg_en, dbg_mem_sel, ddr_ready);

endinterface

`default_nettype wire

// File: source/ctl_capture.sv
// -------------------------------------------------------------------------
// A held FLR request gives a done pulse every other cycle
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

module ctl_capture
(
   input  wire logic                         clk,
   input  wire logic                         sync_rst_n,

   input  wire logic                         flr_assert,
   output logic                              flr_done,

   input  wire logic [31:0]                  ctl_word,
   input  wire logic                         ext_ddr_ready,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0] lcl_ddr_ready,

   ctl_if.capture                            ctl
);

   // Control word fields
   localparam int DBG_EN_BIT = 31;
   localparam int DBG_SEL_HI = 30;
   localparam int DBG_SEL_LO = 28;

   logic [`CFG_NUM_SCRB-1:0] scrb_en_q;
   logic                     dbg_en_q;
   logic [2:0]               dbg_mem_sel_q;
   logic                     ext_ready_q;
   logic                     flr_assert_q;

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_en_q     <= '0;
         dbg_en_q      <= 1'b0;
         dbg_mem_sel_q <= '0;
         ext_ready_q   <= 1'b0;
         flr_assert_q  <= 1'b0;
         flr_done      <= 1'b0;
      end
      else
      begin
         scrb_en_q     <= ctl_word[`CFG_NUM_SCRB-1:0];
         dbg_en_q      <= ctl_word[DBG_EN_BIT];
         dbg_mem_sel_q <= ctl_word[DBG_SEL_HI:DBG_SEL_LO];
         ext_ready_q   <= ext_ddr_ready;
         flr_assert_q  <= flr_assert;
         // Drop for a cycle after each pulse
         flr_done      <= flr_assert_q && !flr_done;
      end
   end

   assign ctl.scrb_en     = scrb_en_q;
   assign ctl.dbg_en      = dbg_en_q;
   assign ctl.dbg_mem_sel = dbg_mem_sel_q;

   // External channel sits between local channels 1 and 2
   assign ctl.ddr_ready = {lcl_ddr_ready[2], ext_ready_q, lcl_ddr_ready[1:0]};

endmodule

`default_nettype wire

// File: source/ddr_stat_relay.sv
// -------------------------------------------------------------------------
// Fixed latency of STAGES cycles each way, no back-pressure
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

module ddr_stat_relay
#(
   parameter int STAGES = `CFG_DDR_STAT_STAGES
)
(
   input  wire logic                        clk,
   input  wire logic                        sync_rst_n,

   // Host toward controller
   input  wire logic                        stat_wr_in,
   input  wire logic                        stat_rd_in,
   input  wire logic [`CFG_STAT_ADDR_W-1:0] stat_addr_in,
   input  wire logic [`CFG_STAT_DATA_W-1:0] stat_wdata_in,
   output logic                             stat_wr_out,
   output logic                             stat_rd_out,
   output logic [`CFG_STAT_ADDR_W-1:0]      stat_addr_out,
   output logic [`CFG_STAT_DATA_W-1:0]      stat_wdata_out,

   // Controller back to host
   input  wire logic                        ack_in,
   input  wire logic [`CFG_STAT_INT_W-1:0]  int_in,
   input  wire logic [`CFG_STAT_DATA_W-1:0] rdata_in,
   output logic                             ack_out,
   output logic [`CFG_STAT_INT_W-1:0]       int_out,
   output logic [`CFG_STAT_DATA_W-1:0]      rdata_out
);

   localparam int REQ_W = `CFG_STAT_ADDR_W + `CFG_STAT_DATA_W;
   localparam int ACK_W = `CFG_STAT_INT_W + `CFG_STAT_DATA_W;

   // Stage 0 takes the inputs, the last stage drives the outputs
   logic [STAGES-1:0][1:0]       req_strb;
   logic [STAGES-1:0][REQ_W-1:0] req_data;
   logic [STAGES-1:0]            ack_strb;
   logic [STAGES-1:0][ACK_W-1:0] ack_data;

   // Strobes
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         req_strb <= '0;
         ack_strb <= '0;
      end
      else
      begin
         req_strb[0] <= {stat_wr_in, stat_rd_in};
         ack_strb[0] <= ack_in;
         for (int i = 1; i < STAGES; i++)
         begin
            req_strb[i] <= req_strb[i-1];
            ack_strb[i] <= ack_strb[i-1];
         end
      end
   end

   // Address, data and interrupt payload
   always_ff @(posedge clk)
   begin
      req_data[0] <= {stat_addr_in, stat_wdata_in};
      ack_data[0] <= {int_in, rdata_in};
      for (int i = 1; i < STAGES; i++)
      begin
         req_data[i] <= req_data[i-1];
         ack_data[i] <= ack_data[i-1];
      end
   end

   assign {stat_wr_out, stat_rd_out}      = req_strb[STAGES-1];
   assign {stat_addr_out, stat_wdata_out} = req_data[STAGES-1];
   assign ack_out                         = ack_strb[STAGES-1];
   assign {int_out, rdata_out}            = ack_data[STAGES-1];

endmodule

`default_nettype wire

// File: source/status_report.sv
// -------------------------------------------------------------------------
// Memory selects past the last scrubber read scrubber 0
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

module status_report
   import cl_ctl_status_pkg::*;
(
   input  wire logic                                             clk,
   input  wire logic                                             sync_rst_n,

   ctl_if.report                                                 ctl,

   input  wire logic [`CFG_NUM_SCRB-1:0][`CFG_SCRB_STATE_W-1:0]  scrb_state,
   input  wire logic [`CFG_NUM_SCRB-1:0]                         scrb_done,
   input  wire logic [`CFG_NUM_SCRB-1:0][`CFG_SCRB_ADDR_W-1:0]   scrb_addr,

   output logic [31:0]                                           status0,
   output logic [31:0]                                           id0,
   output logic [31:0]                                           id1
);

   localparam int SEL_W = $clog2(`CFG_NUM_SCRB);

   status_word_u                status_nxt;
   logic [SEL_W-1:0]            sel_idx;
   logic [`CFG_SCRB_ADDR_W-1:0] sel_addr;

   // -----------------------------------------------------------------------
   // Status word
   // -----------------------------------------------------------------------
   always_comb
   begin
      status_nxt = '0;
      if (ctl.dbg_en)
      begin
         for (int i = 0; i < `CFG_NUM_SCRB; i++)
         begin
            status_nxt.dbg.scrb_fld[i] = {1'b0, scrb_state[i]};
         end
         status_nxt.dbg.marker    = `CFG_STATUS_MARKER;
         status_nxt.dbg.scrb_done = scrb_done;
         status_nxt.dbg.ddr_ready = ctl.ddr_ready;
      end
      else
      begin
         status_nxt.nrm.signature = `CFG_STATUS_SIGNATURE;
         status_nxt.nrm.marker    = `CFG_STATUS_MARKER;
         status_nxt.nrm.scrb_done = scrb_done;
         status_nxt.nrm.ddr_ready = ctl.ddr_ready;
      end
   end

   // -----------------------------------------------------------------------
   // Debug address readout
   // -----------------------------------------------------------------------
   always_comb
   begin
      if (ctl.dbg_mem_sel < `CFG_NUM_SCRB)
         sel_idx = ctl.dbg_mem_sel[SEL_W-1:0];
      else
         sel_idx = '0;
   end

   assign sel_addr = scrb_addr[sel_idx];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         status0 <= '0;
         id0     <= `CFG_CL_SH_ID0;
         id1     <= `CFG_CL_SH_ID1;
      end
      else
      begin
         status0 <= status_nxt;
         if (ctl.dbg_en)
         begin
            // Low half in id0, high half in id1
            id0 <= sel_addr[31:0];
            id1 <= sel_addr[`CFG_SCRB_ADDR_W-1:32];
         end
         else
         begin
            id0 <= `CFG_CL_SH_ID0;
            id1 <= `CFG_CL_SH_ID1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/cl_ctl_status_top.sv
// -------------------------------------------------------------------------
// sync_rst_n must already be synchronized to clk
// -------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

module cl_ctl_status_top
(
   input  wire logic                                                 clk,
   input  wire logic                                                 sync_rst_n,

   // FLR
   input  wire logic                                                 flr_assert,
   output logic                                                      flr_done,

   // Host control and readiness
   input  wire logic [31:0]                                          ctl_word,
   input  wire logic                                                 ext_ddr_ready,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0]                         lcl_ddr_ready,
   output logic [`CFG_NUM_SCRB-1:0]                                  scrb_en,

   // Scrubber progress
   input  wire logic [`CFG_NUM_SCRB-1:0][`CFG_SCRB_STATE_W-1:0]      scrb_state,
   input  wire logic [`CFG_NUM_SCRB-1:0]                             scrb_done,
   input  wire logic [`CFG_NUM_SCRB-1:0][`CFG_SCRB_ADDR_W-1:0]       scrb_addr,

   // Status readout
   output logic [31:0]                                               status0,
   output logic [31:0]                                               id0,
   output logic [31:0]                                               id1,

   // Stat requests from host
   input  wire logic [`CFG_NUM_DDR_STAT-1:0]                         stat_wr,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0]                         stat_rd,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_ADDR_W-1:0]   stat_addr,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_DATA_W-1:0]   stat_wdata,
   output logic [`CFG_NUM_DDR_STAT-1:0]                              stat_ack,
   output logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_INT_W-1:0]         stat_int,
   output logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_DATA_W-1:0]        stat_rdata,

   // Stat requests toward the DDR controller
   output logic [`CFG_NUM_DDR_STAT-1:0]                              ddr_stat_wr,
   output logic [`CFG_NUM_DDR_STAT-1:0]                              ddr_stat_rd,
   output logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_ADDR_W-1:0]        ddr_stat_addr,
   output logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_DATA_W-1:0]        ddr_stat_wdata,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0]                         ddr_stat_ack,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_INT_W-1:0]    ddr_stat_int,
   input  wire logic [`CFG_NUM_DDR_STAT-1:0][`CFG_STAT_DATA_W-1:0]   ddr_stat_rdata
);

   ctl_if ctl_bus ();

   assign scrb_en = ctl_bus.scrb_en;

   ctl_capture i_ctl_capture (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .flr_assert    (flr_assert),
      .flr_done      (flr_done),
      .ctl_word      (ctl_word),
      .ext_ddr_ready (ext_ddr_ready),
      .lcl_ddr_ready (lcl_ddr_ready),
      .ctl           (ctl_bus.capture)
   );

   // One relay per DDR stat channel
   for (genvar i = 0; i < `CFG_NUM_DDR_STAT; i++)
   begin : g_stat
      ddr_stat_relay #(.STAGES(`CFG_DDR_STAT_STAGES)) i_relay (
         .clk            (clk),
         .sync_rst_n     (sync_rst_n),
         .stat_wr_in     (stat_wr[i]),
         .stat_rd_in     (stat_rd[i]),
         .stat_addr_in   (stat_addr[i]),
         .stat_wdata_in  (stat_wdata[i]),
         .stat_wr_out    (ddr_stat_wr[i]),
         .stat_rd_out    (ddr_stat_rd[i]),
         .stat_addr_out  (ddr_stat_addr[i]),
         .stat_wdata_out (ddr_stat_wdata[i]),
         .ack_in         (ddr_stat_ack[i]),
         .int_in         (ddr_stat_int[i]),
         .rdata_in       (ddr_stat_rdata[i]),
         .ack_out        (stat_ack[i]),
         .int_out        (stat_int[i]),
         .rdata_out      (stat_rdata[i])
      );
   end

   status_report i_status_report (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl        (ctl_bus.report),
      .scrb_state (scrb_state),
      .scrb_done  (scrb_done),
      .scrb_addr  (scrb_addr),
      .status0    (status0),
      .id0        (id0),
      .id1        (id1)
   );

endmodule

`default_nettype wire

// File: dv/tb_cl_ctl_status.sv
// ---------------------------------------------------------------------------
// Inputs are driven and outputs sampled 2 time units after the rising edge
// The run stops at the first mismatch
// ---------------------------------------------------------------------------
`default_nettype none

`include "cl_ctl_status_cfg.svh"

module tb_cl_ctl_status;

   localparam int CLK_PERIOD = 20;
   localparam int DRIVE_DLY  = 2;
   localparam int NUM_TASKS  = 5;
   localparam int WDOG_TIME  = NUM_TASKS * 200 * CLK_PERIOD;
   localparam int NS         = `CFG_NUM_DDR_STAT;
   localparam int NSCRB      = `CFG_NUM_SCRB;
   localparam int STAGES     = `CFG_DDR_STAT_STAGES;
   localparam int NUM_REQ    = 20;

   logic                                            clk;
   logic                                            sync_rst_n;
   logic                                            flr_assert;
   logic                                            flr_done;
   logic [31:0]                                     ctl_word;
   logic                                            ext_ddr_ready;
   logic [NS-1:0]                                   lcl_ddr_ready;
   logic [NSCRB-1:0]                                scrb_en;
   logic [NSCRB-1:0][`CFG_SCRB_STATE_W-1:0]         scrb_state;
   logic [NSCRB-1:0]                                scrb_done;
   logic [NSCRB-1:0][`CFG_SCRB_ADDR_W-1:0]          scrb_addr;
   logic [31:0]                                     status0;
   logic [31:0]                                     id0;
   logic [31:0]                                     id1;
   logic [NS-1:0]                                   stat_wr;
   logic [NS-1:0]                                   stat_rd;
   logic [NS-1:0][`CFG_STAT_ADDR_W-1:0]             stat_addr;
   logic [NS-1:0][`CFG_STAT_DATA_W-1:0]             stat_wdata;
   logic [NS-1:0]                                   stat_ack;
   logic [NS-1:0][`CFG_STAT_INT_W-1:0]              stat_int;
   logic [NS-1:0][`CFG_STAT_DATA_W-1:0]             stat_rdata;
   logic [NS-1:0]                                   ddr_stat_wr;
   logic [NS-1:0]                                   ddr_stat_rd;
   logic [NS-1:0][`CFG_STAT_ADDR_W-1:0]             ddr_stat_addr;
   logic [NS-1:0][`CFG_STAT_DATA_W-1:0]             ddr_stat_wdata;
   logic [NS-1:0]                                   ddr_stat_ack;
   logic [NS-1:0][`CFG_STAT_INT_W-1:0]              ddr_stat_int;
   logic [NS-1:0][`CFG_STAT_DATA_W-1:0]             ddr_stat_rdata;

   cl_ctl_status_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Failure reporting and helpers
   // ------------------------------------------------------------------------
   task automatic stop_with_failure();
      $display("Test failures found");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic expect_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      assert (got === exp)
      else
      begin
         $display("** Error at time %0t: %s got %0h, expected %0h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #(DRIVE_DLY);
   endtask

   initial
   begin
      #(WDOG_TIME);
      $display("Timeout: the tests did not finish by time %0t", $time);
      stop_with_failure();
   end

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic reset_values_test();
      expect_eq("flr_done", flr_done, 0);
      expect_eq("scrb_en", scrb_en, 0);
      expect_eq("status0", status0, 0);
      expect_eq("id0", id0, `CFG_CL_SH_ID0);
      expect_eq("id1", id1, `CFG_CL_SH_ID1);
      expect_eq("ddr_stat_wr", ddr_stat_wr, 0);
      expect_eq("ddr_stat_rd", ddr_stat_rd, 0);
      expect_eq("stat_ack", stat_ack, 0);
   endtask

   task automatic normal_status_test();
      logic [NS:0] ready;
      for (int n = 0; n < 4; n++)
      begin
         ctl_word      = $urandom & 32'h7FFF_FFFF;
         ext_ddr_ready = 1'($urandom);
         lcl_ddr_ready = NS'($urandom);
         scrb_done     = NSCRB'($urandom);
         next_cycle();
         next_cycle();
         ready = {lcl_ddr_ready[2], ext_ddr_ready, lcl_ddr_ready[1:0]};
         expect_eq("scrb_en", scrb_en, ctl_word[3:0]);
         expect_eq("status0 normal", status0,
                   {`CFG_STATUS_SIGNATURE, `CFG_STATUS_MARKER, scrb_done, ready});
         expect_eq("id0", id0, `CFG_CL_SH_ID0);
         expect_eq("id1", id1, `CFG_CL_SH_ID1);
      end
   endtask

   task automatic debug_status_test();
      logic [NS:0]  ready;
      logic [31:0]  exp_status;
      int           idx;
      for (int sel = 0; sel < 8; sel++)
      begin
         ctl_word      = ($urandom & 32'h0FFF_FFFF) | 32'h8000_0000 | (sel << 28);
         ext_ddr_ready = 1'($urandom);
         lcl_ddr_ready = NS'($urandom);
         scrb_done     = NSCRB'($urandom);
         for (int i = 0; i < NSCRB; i++)
         begin
            scrb_state[i] = `CFG_SCRB_STATE_W'($urandom);
            scrb_addr[i]  = {$urandom, $urandom};
         end
         next_cycle();
         next_cycle();
         ready      = {lcl_ddr_ready[2], ext_ddr_ready, lcl_ddr_ready[1:0]};
         exp_status = {1'b0, scrb_state[3], 1'b0, scrb_state[2], 1'b0, scrb_state[1],
                       1'b0, scrb_state[0], 4'h0, `CFG_STATUS_MARKER, scrb_done, ready};
         // Selects 4 to 7 fall back to DDR A
         idx = (sel < 4) ? sel : 0;
         expect_eq("status0 debug", status0, exp_status);
         expect_eq("id0 debug", id0, scrb_addr[idx][31:0]);
         expect_eq("id1 debug", id1, scrb_addr[idx][63:32]);
      end
      ctl_word = '0;
   endtask

   task automatic flr_request(input int hold);
      // Let earlier pulses drain
      repeat (3) next_cycle();
      flr_assert = 1'b1;
      for (int n = 1; n <= hold + 4; n++)
      begin
         next_cycle();
         if (n == hold)
            flr_assert = 1'b0;
         // First pulse 2 cycles in, then every other cycle while held
         expect_eq("flr_done", flr_done, (n >= 2) && (n <= hold + 1) && (n % 2 == 0));
      end
   endtask

   task automatic flr_test();
      flr_request(1);
      flr_request(8);
   endtask

   task automatic stat_relay_test();
      logic [NS-1:0]                        wr_h    [NUM_REQ];
      logic [NS-1:0]                        rd_h    [NUM_REQ];
      logic [NS-1:0][`CFG_STAT_ADDR_W-1:0]  addr_h  [NUM_REQ];
      logic [NS-1:0][`CFG_STAT_DATA_W-1:0]  wdata_h [NUM_REQ];
      logic [NS-1:0]                        ack_h   [NUM_REQ];
      logic [NS-1:0][`CFG_STAT_INT_W-1:0]   int_h   [NUM_REQ];
      logic [NS-1:0][`CFG_STAT_DATA_W-1:0]  rdata_h [NUM_REQ];
      int                                   k;
      for (int n = 0; n < NUM_REQ + STAGES; n++)
      begin
         if (n < STAGES)
         begin
            // Nothing may come out early
            expect_eq("ddr_stat_wr early", ddr_stat_wr, 0);
            expect_eq("ddr_stat_rd early", ddr_stat_rd, 0);
            expect_eq("stat_ack early", stat_ack, 0);
         end
         else
         begin
            k = n - STAGES;
            expect_eq("ddr_stat_wr", ddr_stat_wr, wr_h[k]);
            expect_eq("ddr_stat_rd", ddr_stat_rd, rd_h[k]);
            expect_eq("ddr_stat_addr", ddr_stat_addr, addr_h[k]);
            expect_eq("ddr_stat_wdata", ddr_stat_wdata, wdata_h[k]);
            expect_eq("stat_ack", stat_ack, ack_h[k]);
            expect_eq("stat_int", stat_int, int_h[k]);
            expect_eq("stat_rdata", stat_rdata, rdata_h[k]);
         end
         if (n < NUM_REQ)
         begin
            for (int c = 0; c < NS; c++)
            begin
               stat_wr[c]        = 1'($urandom);
               stat_rd[c]        = 1'($urandom);
               stat_addr[c]      = `CFG_STAT_ADDR_W'($urandom);
               stat_wdata[c]     = $urandom;
               ddr_stat_ack[c]   = 1'($urandom);
               ddr_stat_int[c]   = `CFG_STAT_INT_W'($urandom);
               ddr_stat_rdata[c] = $urandom;
            end
            wr_h[n]    = stat_wr;
            rd_h[n]    = stat_rd;
            addr_h[n]  = stat_addr;
            wdata_h[n] = stat_wdata;
            ack_h[n]   = ddr_stat_ack;
            int_h[n]   = ddr_stat_int;
            rdata_h[n] = ddr_stat_rdata;
         end
         else
         begin
            stat_wr      = '0;
            stat_rd      = '0;
            ddr_stat_ack = '0;
         end
         next_cycle();
      end
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      int seed_val;
      sync_rst_n     = 1'b0;
      flr_assert     = 1'b0;
      ctl_word       = '0;
      ext_ddr_ready  = 1'b0;
      lcl_ddr_ready  = '0;
      scrb_state     = '0;
      scrb_done      = '0;
      scrb_addr      = '0;
      stat_wr        = '0;
      stat_rd        = '0;
      stat_addr      = '0;
      stat_wdata     = '0;
      ddr_stat_ack   = '0;
      ddr_stat_int   = '0;
      ddr_stat_rdata = '0;
      seed_val       = $urandom(61671);

      repeat (4) @(posedge clk);
      #(DRIVE_DLY);
      sync_rst_n = 1'b1;

      reset_values_test();
      normal_status_test();
      debug_status_test();
      flr_test();
      stat_relay_test();

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// File: cl_ctl_status.f
+incdir+include
source/cl_ctl_status_pkg.sv
source/ctl_if.sv
source/ctl_capture.sv
source/ddr_stat_relay.sv
source/status_report.sv
source/cl_ctl_status_top.sv
dv/tb_cl_ctl_status.sv
